// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f project.f --top-module exec_core_tb \
		-Mdir obj_dir -o exec_core_tb
	./obj_dir/exec_core_tb | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: alu/alu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module alu (
	input logic clk,
	input logic reset,
	input logic empty,
	output logic pop,
	input cpu_pkg::issue_t pop_data,
	output logic wb_valid,
	output cpu_pkg::reg_idx_t wb_rd,
	output cpu_pkg::data_t wb_data,
	output logic retire_valid,
	output cpu_pkg::reg_idx_t retire_rd,
	output logic retire_we,
	output cpu_pkg::data_t retire_result,
	output cpu_pkg::flag_e retire_flag,
	output logic branch
);
	import cpu_pkg::*;

	data_t a;
	data_t b;
	data_t result;
	logic [2*`CPU_XLEN:0] wide;
	flag_e flag_q;
	flag_e flag_next;
	logic br_next;

	function automatic logic [2*`CPU_XLEN:0] sext(input data_t x);
		return {{(`CPU_XLEN+1){x[`CPU_XLEN-1]}}, x};
	endfunction

	// Sign bit against the bit above it
	function automatic flag_e sum_flag(input logic [2*`CPU_XLEN:0] sum);
		case ({sum[`CPU_XLEN], sum[`CPU_XLEN-1]})
			2'b01: return FLAG_OVERFLOW;
			2'b10: return FLAG_UNDERFLOW;
			default: return FLAG_NONE;
		endcase
	endfunction

	assign pop = ~empty;
	assign a = pop_data.a;
	assign b = pop_data.b;

	always_comb begin
		wide = '0;
		result = '0;
		flag_next = FLAG_NONE;
		br_next = 1'b0;
		case (pop_data.op)
			ALU_ADD: begin
				wide = sext(a) + sext(b);
				result = wide[`CPU_XLEN-1:0];
				flag_next = sum_flag(wide);
			end
			ALU_SUB: begin
				wide = sext(a) - sext(b);
				result = wide[`CPU_XLEN-1:0];
				flag_next = sum_flag(wide);
			end
			ALU_MUL: begin
				wide = {1'b0, {{`CPU_XLEN{1'b0}}, a} * {{`CPU_XLEN{1'b0}}, b}};
				result = wide[`CPU_XLEN-1:0];
				if (|wide[2*`CPU_XLEN-1:`CPU_XLEN])
					flag_next = FLAG_OVERFLOW;
			end
			ALU_DIVU: begin
				if (b == '0) begin
					result = '1;
					flag_next = FLAG_EXCEPTION;
				end else begin
					result = a / b;
				end
			end
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_NOT: result = ~b;
			ALU_CMP: begin
				if (a == b)
					flag_next = FLAG_EQUAL;
				else if (a > b)
					flag_next = FLAG_ABOVE;
			end
			ALU_BRFL: begin
				result = a;
				flag_next = flag_q;
				br_next = (flag_q == flag_e'(b[2:0]));
			end
			default: flag_next = flag_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			retire_valid <= 1'b0;
			wb_valid <= 1'b0;
			branch <= 1'b0;
			flag_q <= FLAG_NONE;
		end else begin
			retire_valid <= pop;
			wb_valid <= pop & pop_data.we;
			branch <= pop & br_next;
			if (pop)
				flag_q <= flag_next;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			retire_rd <= pop_data.rd;
			retire_we <= pop_data.we;
			retire_result <= result;
		end
	end

	// Writeback shares the retire registers
	assign wb_rd = retire_rd;
	assign wb_data = retire_result;
	assign retire_flag = flag_q;

endmodule

// File: common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path width
`define CPU_XLEN 32

`define CPU_NREGS 8

// Records between decoder and ALU
`define CPU_QUEUE_DEPTH 4

`endif

// File: common/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

	// Instruction word
	//   [31:29] opcode, [28:26] rs, [25:23] rt, [22:20] rd
	//   [5:0] func for TYPE_R, [15:0] imm for the I-type instructions
	//   Operand a from rs; operand b from rt for TYPE_R, else sign-extended imm
	//   BRFL tests the flag against imm[2:0]

	typedef logic [`CPU_XLEN-1:0] data_t;
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

	typedef enum logic [2:0] {
		ADDI   = 3'b000,
		SUBI   = 3'b001,
		TYPE_R = 3'b010,
		ANDI   = 3'b011,
		ORI    = 3'b100,
		BRFL   = 3'b101
	} opcode_e;

	typedef enum logic [5:0] {
		ADD = 6'b100000,
		SUB = 6'b100010,
		MUL = 6'b000010,
		DIV = 6'b000001,
		AND = 6'b100100,
		OR  = 6'b100101,
		NOT = 6'b100111,
		CMP = 6'b101010
	} func_e;

	// One entry per distinct ALU behavior
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_MUL,
		ALU_DIVU,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_CMP,
		ALU_BRFL
	} alu_op_e;

	typedef enum logic [2:0] {
		FLAG_NONE      = 3'd0,
		FLAG_EQUAL     = 3'd1,
		FLAG_EXCEPTION = 3'd2,
		FLAG_OVERFLOW  = 3'd3,
		FLAG_UNDERFLOW = 3'd4,
		FLAG_ABOVE     = 3'd5
	} flag_e;

	typedef struct packed {
		alu_op_e op;
		data_t a;
		data_t b;
		reg_idx_t rd;
		logic we;
	} issue_t;

endpackage

// File: hdl/exec_core.sv
`timescale 1ns/100ps

module exec_core (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic [31:0] instr,
	output logic busy,
	output logic retire_valid,
	output cpu_pkg::reg_idx_t retire_rd,
	output logic retire_we,
	output cpu_pkg::data_t retire_result,
	output cpu_pkg::flag_e retire_flag,
	output logic branch
);
	import cpu_pkg::*;

	logic push;
	issue_t push_data;
	logic full;
	logic pop;
	issue_t pop_data;
	logic empty;
	logic wb_valid;
	reg_idx_t wb_rd;
	data_t wb_data;

	inst_decoder decoder0 (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.busy(busy),
		.push(push),
		.push_data(push_data),
		.full(full),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	op_queue #(
		.payload_t(issue_t)
	) queue0 (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_data(push_data),
		.full(full),
		.pop(pop),
		.pop_data(pop_data),
		.empty(empty)
	);

	alu alu0 (
		.clk(clk),
		.reset(reset),
		.empty(empty),
		.pop(pop),
		.pop_data(pop_data),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_we(retire_we),
		.retire_result(retire_result),
		.retire_flag(retire_flag),
		.branch(branch)
	);

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module inst_decoder (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic [31:0] instr,
	output logic busy,
	output logic push,
	output cpu_pkg::issue_t push_data,
	input logic full,
	input logic wb_valid,
	input cpu_pkg::reg_idx_t wb_rd,
	input cpu_pkg::data_t wb_data
);
	import cpu_pkg::*;

	opcode_e opcode;
	func_e func;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	data_t imm_ext;
	data_t rs_data;
	data_t rt_data;
	data_t regs [`CPU_NREGS];
	logic [`CPU_NREGS-1:0] pending;
	alu_op_e op;
	logic legal;
	logic use_rt;
	logic we;
	logic hazard;
	logic accept;
	logic issue_valid;

	assign opcode = opcode_e'(instr[31:29]);
	assign func = func_e'(instr[5:0]);
	assign rs = instr[28:26];
	assign rt = instr[25:23];
	assign rd = instr[22:20];
	assign imm_ext = {{(`CPU_XLEN-16){instr[15]}}, instr[15:0]};

	always_comb begin
		op = ALU_OR;
		legal = 1'b1;
		case (opcode)
			ADDI: op = ALU_ADD;
			SUBI: op = ALU_SUB;
			ANDI: op = ALU_AND;
			ORI: op = ALU_OR;
			BRFL: op = ALU_BRFL;
			TYPE_R: begin
				case (func)
					ADD: op = ALU_ADD;
					SUB: op = ALU_SUB;
					MUL: op = ALU_MUL;
					DIV: op = ALU_DIVU;
					AND: op = ALU_AND;
					OR: op = ALU_OR;
					NOT: op = ALU_NOT;
					CMP: op = ALU_CMP;
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	// Undefined codes go down as an OR that writes nothing
	assign use_rt = (opcode == TYPE_R);
	assign we = legal && op != ALU_CMP && op != ALU_BRFL;

	assign rs_data = (rs == '0) ? '0 : regs[rs];
	assign rt_data = (rt == '0) ? '0 : regs[rt];

	// Stall on any register still waiting for its writeback
	assign hazard = pending[rs] | (use_rt & pending[rt]) | (we & pending[rd]);
	assign busy = hazard | full;
	assign accept = instr_valid & ~busy;

	assign push = issue_valid & ~full;

	always_ff @(posedge clk) begin
		if (!reset) begin
			issue_valid <= 1'b0;
			pending <= '0;
		end else begin
			if (accept)
				issue_valid <= 1'b1;
			else if (push)
				issue_valid <= 1'b0;
			if (wb_valid)
				pending[wb_rd] <= 1'b0;
			if (accept && we && rd != '0)
				pending[rd] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			push_data <= '{op: op, a: rs_data, b: use_rt ? rt_data : imm_ext, rd: rd, we: we};
	end

	// r0 is never written
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (wb_valid && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

endmodule

// File: hdl/op_queue.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module op_queue #(
	parameter type payload_t = logic,
	parameter int depth = `CPU_QUEUE_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	output logic full,
	input logic pop,
	output payload_t pop_data,
	output logic empty
);
	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);
	localparam logic [aw-1:0] last_ptr = aw'(depth - 1);
	localparam logic [cw-1:0] full_count = cw'(depth);

	payload_t mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == full_count);
	assign empty = (count == '0);

	// A full queue still takes a push alongside a pop
	assign do_push = push & (~full | pop);
	assign do_pop = pop & ~empty;

	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

// File: project.f
+incdir+common
common/cpu_pkg.sv
hdl/inst_decoder.sv
hdl/op_queue.sv
alu/alu.sv
hdl/exec_core.sv
tb/exec_core_asserts.sv
tb/exec_core_tb.sv

// File: tb/exec_core_asserts.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module exec_core_asserts #(
	parameter int depth = `CPU_QUEUE_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic full,
	input logic empty,
	input logic [$clog2(depth+1)-1:0] count
);
	localparam int cw = $clog2(depth + 1);
	localparam logic [cw-1:0] max_count = cw'(depth);

	// A full queue only takes a push together with a pop
	push_when_full: assert property (@(posedge clk) disable iff (!reset)
		(push && full) |-> pop)
		else $error("push into a full queue without a pop");

	pop_when_empty: assert property (@(posedge clk) disable iff (!reset)
		!(pop && empty))
		else $error("pop from an empty queue");

	count_in_range: assert property (@(posedge clk) disable iff (!reset)
		count <= max_count)
		else $error("queue count %0d above depth %0d", count, depth);

endmodule

// File: tb/exec_core_tb.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module exec_core_tb;
	import cpu_pkg::*;

	// Instructions sent by tests 1 to 6
	localparam int total_instrs = 18 + 12 + 18 + 16 + 16 + 15;
	localparam int cycle_limit = 8 * total_instrs + 100;

	typedef struct packed {
		logic [2:0] rd;
		logic we;
		logic chk_res;
		logic [31:0] result;
		logic [2:0] flag;
		logic br;
	} expect_t;

	logic clk = 1'b0;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic busy;
	logic retire_valid;
	reg_idx_t retire_rd;
	logic retire_we;
	data_t retire_result;
	flag_e retire_flag;
	logic branch;

	logic [31:0] lfsr_state;
	logic [31:0] model_regs [`CPU_NREGS];
	logic [2:0] model_flag;
	expect_t exp_q [$];
	expect_t head;
	int cycle_count = 0;
	int error_count = 0;
	int retired = 0;
	int failed_tests = 0;
	int test_num = 0;
	int test_errors_at;
	int test_retired_at;
	string test_name;

	exec_core dut0 (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.busy(busy),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_we(retire_we),
		.retire_result(retire_result),
		.retire_flag(retire_flag),
		.branch(branch)
	);

	bind op_queue exec_core_asserts #(
		.depth(depth)
	) asserts0 (
		.clk(clk),
		.reset(reset),
		.push(push),
		.pop(pop),
		.full(full),
		.empty(empty),
		.count(count)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = next_lfsr(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [2:0] any_reg();
		return 3'(take_bits(3));
	endfunction

	function automatic logic [2:0] pick_dest();
		return 3'(1 + take_bits(3) % 7);
	endfunction

	function automatic logic [31:0] enc_r(input func_e fn, input logic [2:0] rs,
			input logic [2:0] rt, input logic [2:0] rd);
		return {TYPE_R, rs, rt, rd, 14'b0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e opc, input logic [2:0] rs,
			input logic [2:0] rd, input logic [15:0] imm);
		return {opc, rs, 3'b000, rd, 4'b0, imm};
	endfunction

	// Signed overflow, then the sign of the wrapped result picks the flag
	function automatic logic [2:0] add_sub_flag(input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] r, input logic is_sub);
		logic ovf;
		if (is_sub)
			ovf = (a[31] != b[31]) && (r[31] != a[31]);
		else
			ovf = (a[31] == b[31]) && (r[31] != a[31]);
		if (!ovf)
			return FLAG_NONE;
		return r[31] ? FLAG_OVERFLOW : FLAG_UNDERFLOW;
	endfunction

	// Instructions apply in order, as the stall keeps them
	task automatic predict(input logic [31:0] word);
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] r;
		logic [63:0] prod;
		expect_t e;
		rs = word[28:26];
		rt = word[25:23];
		rd = word[22:20];
		imm = {{16{word[15]}}, word[15:0]};
		a = model_regs[rs];
		b = (word[31:29] == TYPE_R) ? model_regs[rt] : imm;
		r = '0;
		e = '0;
		e.rd = rd;
		e.we = 1'b1;
		e.chk_res = 1'b1;
		case (word[31:29])
			ADDI: begin
				r = a + b;
				model_flag = add_sub_flag(a, b, r, 1'b0);
			end
			SUBI: begin
				r = a - b;
				model_flag = add_sub_flag(a, b, r, 1'b1);
			end
			ANDI: begin
				r = a & b;
				model_flag = FLAG_NONE;
			end
			ORI: begin
				r = a | b;
				model_flag = FLAG_NONE;
			end
			BRFL: begin
				r = a;
				e.we = 1'b0;
				e.br = (model_flag == imm[2:0]);
			end
			TYPE_R: begin
				case (word[5:0])
					ADD: begin
						r = a + b;
						model_flag = add_sub_flag(a, b, r, 1'b0);
					end
					SUB: begin
						r = a - b;
						model_flag = add_sub_flag(a, b, r, 1'b1);
					end
					MUL: begin
						prod = {32'b0, a} * {32'b0, b};
						r = prod[31:0];
						model_flag = (prod[63:32] != 0) ? FLAG_OVERFLOW : FLAG_NONE;
					end
					DIV: begin
						if (b == 32'd0) begin
							r = 32'hFFFF_FFFF;
							model_flag = FLAG_EXCEPTION;
						end else begin
							r = a / b;
							model_flag = FLAG_NONE;
						end
					end
					AND: begin
						r = a & b;
						model_flag = FLAG_NONE;
					end
					OR: begin
						r = a | b;
						model_flag = FLAG_NONE;
					end
					NOT: begin
						r = ~b;
						model_flag = FLAG_NONE;
					end
					CMP: begin
						e.we = 1'b0;
						e.chk_res = 1'b0;
						if (a == b)
							model_flag = FLAG_EQUAL;
						else if (a > b)
							model_flag = FLAG_ABOVE;
						else
							model_flag = FLAG_NONE;
					end
					default: begin
						e.we = 1'b0;
						e.chk_res = 1'b0;
						model_flag = FLAG_NONE;
					end
				endcase
			end
			default: begin
				e.we = 1'b0;
				e.chk_res = 1'b0;
				model_flag = FLAG_NONE;
			end
		endcase
		e.result = r;
		e.flag = model_flag;
		if (e.we && rd != 3'd0)
			model_regs[rd] = r;
		exp_q.push_back(e);
	endtask

	// Called at a rising edge, returns at the edge that accepts the word
	task automatic send(input logic [31:0] word);
		instr_valid <= 1'b1;
		instr <= word;
		@(negedge clk);
		while (busy)
			@(negedge clk);
		predict(word);
		@(posedge clk);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] want,
			input logic [31:0] got);
		$display("FAIL at %0t: %s expected %h, got %h", $time, what, want, got);
		error_count++;
	endtask

	task automatic start_test(input string name);
		test_num++;
		test_name = name;
		test_errors_at = error_count;
		test_retired_at = retired;
	endtask

	task automatic finish_test();
		int errs;
		instr_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		errs = error_count - test_errors_at;
		if (errs != 0)
			failed_tests++;
		$display("test %0d %s: %0d retired, %0d errors", test_num, test_name,
			retired - test_retired_at, errs);
	endtask

	always @(negedge clk) begin
		if (reset && retire_valid) begin
			retired++;
			assert (exp_q.size() != 0) else begin
				$display("Error at %0t: an instruction retired that was never accepted", $time);
				error_count++;
			end
			if (exp_q.size() != 0) begin
				head = exp_q.pop_front();
				assert (retire_we === head.we)
					else report_mismatch("retire_we", 32'(head.we), 32'(retire_we));
				if (head.we) begin
					assert (retire_rd === head.rd)
						else report_mismatch("retire_rd", 32'(head.rd), 32'(retire_rd));
				end
				if (head.chk_res) begin
					assert (retire_result === head.result)
						else report_mismatch("retire_result", head.result, retire_result);
				end
				assert (retire_flag === head.flag)
					else report_mismatch("retire_flag", 32'(head.flag), 32'(retire_flag));
				assert (branch === head.br)
					else report_mismatch("branch", 32'(head.br), 32'(branch));
			end
		end else if (reset) begin
			assert (branch === 1'b0) else begin
				$display("Error at %0t: branch is high on a cycle without a retire", $time);
				error_count++;
			end
		end
	end

	initial begin
		logic [2:0] last;
		logic [2:0] src;
		logic [2:0] dst;
		int sel;
		reset = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		lfsr_state = 32'h5db52a30;
		model_flag = FLAG_NONE;
		for (int i = 0; i < `CPU_NREGS; i++)
			model_regs[i] = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;

		start_test("loads then add/sub");
		for (int i = 0; i < 8; i++)
			send(enc_i((i % 2 == 0) ? ADDI : ORI, 3'd0, pick_dest(), 16'(take_bits(16))));
		for (int i = 0; i < 10; i++)
			send(enc_r(take_bits(1) != 0 ? ADD : SUB, any_reg(), any_reg(), pick_dest()));
		finish_test();

		start_test("bitwise");
		for (int i = 0; i < 12; i++) begin
			sel = int'(take_bits(3) % 5);
			case (sel)
				0: send(enc_r(AND, any_reg(), any_reg(), pick_dest()));
				1: send(enc_r(OR, any_reg(), any_reg(), pick_dest()));
				2: send(enc_r(NOT, any_reg(), any_reg(), pick_dest()));
				3: send(enc_i(ANDI, any_reg(), pick_dest(), 16'(take_bits(16))));
				default: send(enc_i(ORI, any_reg(), pick_dest(), 16'(take_bits(16))));
			endcase
		end
		finish_test();

		start_test("signed limits");
		// r1 = 0x80000000, then r2..r5 just either side of the limits
		send(enc_i(ADDI, 3'd0, 3'd2, 16'h4000));
		send(enc_r(MUL, 3'd2, 3'd2, 3'd3));
		send(enc_i(ADDI, 3'd0, 3'd4, 16'd8));
		send(enc_r(MUL, 3'd3, 3'd4, 3'd1));
		send(enc_i(SUBI, 3'd1, 3'd2, 16'(1 + take_bits(8))));
		send(enc_i(ADDI, 3'd1, 3'd3, 16'(1 + take_bits(8))));
		send(enc_i(SUBI, 3'd1, 3'd4, 16'(1 + take_bits(8))));
		send(enc_i(ADDI, 3'd1, 3'd5, 16'(1 + take_bits(8))));
		for (int i = 0; i < 10; i++) begin
			sel = int'(take_bits(2));
			src = 3'(2 + take_bits(2));
			dst = 3'(6 + take_bits(1));
			case (sel)
				0: send(enc_r(ADD, src, 3'(2 + take_bits(2)), dst));
				1: send(enc_r(SUB, src, 3'(2 + take_bits(2)), dst));
				2: send(enc_i(ADDI, src, dst, 16'(take_bits(16))));
				default: send(enc_i(SUBI, src, dst, 16'(take_bits(16))));
			endcase
		end
		finish_test();

		start_test("mul/div");
		for (int i = 1; i < 5; i++)
			send(enc_i(ADDI, 3'd0, 3'(i), 16'(take_bits(16))));
		for (int i = 0; i < 6; i++)
			send(enc_r(MUL, 3'(1 + take_bits(2)), 3'(1 + take_bits(2)),
				3'(5 + take_bits(2) % 3)));
		for (int i = 0; i < 6; i++) begin
			src = take_bits(1) != 0 ? 3'd0 : 3'(1 + take_bits(2));
			send(enc_r(DIV, pick_dest(), src, 3'(5 + take_bits(2) % 3)));
		end
		finish_test();

		start_test("cmp/brfl");
		for (int i = 0; i < 8; i++) begin
			src = 3'(1 + take_bits(2));
			dst = take_bits(1) != 0 ? src : 3'(1 + take_bits(2));
			send(enc_r(CMP, src, dst, any_reg()));
			send(enc_i(BRFL, any_reg(), any_reg(), 16'(take_bits(3) % 6)));
		end
		finish_test();

		start_test("dependent chain");
		send(enc_i(ADDI, 3'd0, 3'd1, 16'(take_bits(16))));
		last = 3'd1;
		for (int i = 0; i < 14; i++) begin
			dst = pick_dest();
			sel = int'(take_bits(3) % 5);
			case (sel)
				0: send(enc_r(ADD, last, any_reg(), dst));
				1: send(enc_r(SUB, last, any_reg(), dst));
				2: send(enc_r(MUL, last, any_reg(), dst));
				3: send(enc_i(ADDI, last, dst, 16'(take_bits(16))));
				default: send(enc_i(ORI, last, dst, 16'(take_bits(16))));
			endcase
			last = dst;
		end
		finish_test();

		$display("summary: %0d tests, %0d with errors, %0d retired, %0d errors",
			test_num, failed_tests, retired, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
